//--- common/cp15_cfg.svh
`ifndef CP15_CFG_SVH
`define CP15_CFG_SVH

// Register file geometry
`define CP15_NUM_REGS 16
`define CP15_DATA_W 32
`define CP15_ADDR_W 4

// Reset contents
// Part ID code reported through R0
`define CP15_ID_VALUE 32'h6905_2d00
// MMU off, caches off, legacy bits set
`define CP15_CTRL_RESET 32'h0000_0078

// Registers with a meaning outside the block
`define CP15_REG_CTRL 4'd1
`define CP15_REG_TBASE 4'd2
`define CP15_REG_CACHE 4'd7
`define CP15_REG_TLB 4'd8

`endif

//--- common/cp15_pkg.sv
`include "cp15_cfg.svh"

package cp15_pkg;

  // One requester port where enable without writeEn is a read
  typedef struct packed {
    logic writeEn;
    logic en;
    logic [`CP15_DATA_W-1:0] writeData;
  } cp15Req_t;

  // Merged access after arbitration
  typedef struct packed {
    logic write;
    logic read;
    logic [`CP15_ADDR_W-1:0] addr;
    logic [`CP15_DATA_W-1:0] data;
    logic [2:0] opcode2;
    logic [3:0] crm;
  } cp15Access_t;

  // Cache and TLB maintenance strobes
  typedef struct packed {
    logic flushI;
    logic flushD;
    logic cleanI;
    logic cleanD;
    logic tlbFlushI;
    logic tlbFlushD;
  } cacheOps_t;

  // Always visible to the MMU
  typedef struct packed {
    logic [`CP15_DATA_W-1:0] control;
    logic [`CP15_DATA_W-1:0] tbase;
  } mmuConfig_t;

endpackage

//--- cp15/cp15PortArbiter.sv
`timescale 1ns/100ps
`include "cp15_cfg.svh"

module cp15PortArbiter
  import cp15_pkg::*;
(
  // MCR/MRC side
  input  cp15Req_t cpuReq,
  // Page walker side
  input  cp15Req_t mmuReq,
  input  logic [`CP15_ADDR_W-1:0] addr,
  input  logic [2:0] opcode2,
  input  logic [3:0] crm,
  output cp15Access_t access,
  output logic stall
);

  logic cpuRead;
  logic mmuRead;
  logic bothWrite;
  logic bothEnabled;

  // **************************************************
  // Request classification
  // **************************************************

  // Enable without writeEn means read
  assign cpuRead = cpuReq.en & ~cpuReq.writeEn;
  assign mmuRead = mmuReq.en & ~mmuReq.writeEn;

  assign bothWrite = cpuReq.writeEn & mmuReq.writeEn;
  assign bothEnabled = cpuReq.en & mmuReq.en;

  // **************************************************
  // Merged access
  // **************************************************

  assign access.write = cpuReq.writeEn | mmuReq.writeEn;
  assign access.read = cpuRead | mmuRead;

  // Address and opcode fields are shared by both ports
  assign access.addr = addr;
  assign access.opcode2 = opcode2;
  assign access.crm = crm;

  // MMU data has priority on a write
  always_comb begin
    if (mmuReq.writeEn) begin
      access.data = mmuReq.writeData;
    end else begin
      access.data = cpuReq.writeData;
    end
  end

  // Requesters retry while this is high and
  // the merged access still goes through this cycle
  assign stall = bothWrite | bothEnabled;

endmodule

//--- cp15/cp15RegFile.sv
`timescale 1ns/100ps
`include "cp15_cfg.svh"

module cp15RegFile
  import cp15_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  cp15Access_t access,
  output logic [`CP15_DATA_W-1:0] rd,
  output mmuConfig_t mmuCfg
);

  logic [`CP15_DATA_W-1:0] regs [`CP15_NUM_REGS];
  logic [`CP15_NUM_REGS-1:0] regSel;

  // Reset image of the register set
  function automatic logic [`CP15_DATA_W-1:0] resetValue(input int idx);
    logic [`CP15_DATA_W-1:0] value;
    value = '0;
    if (idx == 0) begin
      value = `CP15_ID_VALUE;
    end else if (idx == int'(`CP15_REG_CTRL)) begin
      value = `CP15_CTRL_RESET;
    end
    return value;
  endfunction

  // **************************************************
  // Address decode
  // **************************************************

  // One-hot register select
  assign regSel = {{(`CP15_NUM_REGS-1){1'b0}}, 1'b1} << access.addr;

  // **************************************************
  // Register write
  // **************************************************

  // Commits on the falling edge, so a write issued after
  // the rising edge is visible for the next cycle's read
  always_ff @(negedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CP15_NUM_REGS; i++) begin
        regs[i] <= resetValue(i);
      end
    end else begin
      // R0 is read only
      for (int j = 1; j < `CP15_NUM_REGS; j++) begin
        if (access.write && regSel[j]) begin
          regs[j] <= access.data;
        end
      end
    end
  end

  // **************************************************
  // Register read
  // **************************************************

  // Zero unless a read is active
  always_comb begin
    rd = '0;
    for (int k = 0; k < `CP15_NUM_REGS; k++) begin
      if (access.read && regSel[k]) begin
        rd = regs[k];
      end
    end
  end

  // Control and table base go straight to the MMU
  assign mmuCfg.control = regs[`CP15_REG_CTRL];
  assign mmuCfg.tbase = regs[`CP15_REG_TBASE];

endmodule

//--- cp15/cacheOpDecoder.sv
`timescale 1ns/100ps
`include "cp15_cfg.svh"

module cacheOpDecoder
  import cp15_pkg::*;
(
  input  cp15Access_t access,
  output cacheOps_t ops
);

  logic opValid;
  logic cacheWrite;
  logic tlbWrite;
  // Order is flushI, flushD, cleanI, cleanD
  logic [3:0] cacheBits;
  // Order is tlbFlushI, tlbFlushD
  logic [1:0] tlbBits;

  // Only opcode2 of 0 or 1 selects a maintenance op
  assign opValid = access.write && (access.opcode2[2:1] == 2'b00);

  assign cacheWrite = opValid && (access.addr == `CP15_REG_CACHE);
  assign tlbWrite = opValid && (access.addr == `CP15_REG_TLB);

  // **************************************************
  // R7 cache operations
  // **************************************************

  always_comb begin
    cacheBits = 4'b0000;
    if (cacheWrite) begin
      case (access.crm)
        4'd7:    cacheBits = 4'b1100;
        4'd5:    cacheBits = 4'b1000;
        4'd6:    cacheBits = 4'b0100;
        4'd11:   cacheBits = 4'b0011;
        4'd10:   cacheBits = 4'b0001;
        4'd15:   cacheBits = 4'b1111;
        // Clean and invalidate D side
        4'd14:   cacheBits = 4'b0101;
        default: cacheBits = 4'b0000;
      endcase
    end
  end

  // **************************************************
  // R8 TLB operations
  // **************************************************

  always_comb begin
    tlbBits = 2'b00;
    if (tlbWrite) begin
      case (access.crm)
        4'd7:    tlbBits = 2'b11;
        4'd5:    tlbBits = 2'b10;
        4'd6:    tlbBits = 2'b01;
        default: tlbBits = 2'b00;
      endcase
    end
  end

  // Strobes follow the write request and are not registered
  assign ops.flushI = cacheBits[3];
  assign ops.flushD = cacheBits[2];
  assign ops.cleanI = cacheBits[1];
  assign ops.cleanD = cacheBits[0];
  assign ops.tlbFlushI = tlbBits[1];
  assign ops.tlbFlushD = tlbBits[0];

endmodule

//--- hdl/systemControl.sv
`timescale 1ns/100ps
`include "cp15_cfg.svh"

module systemControl
  import cp15_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  cp15Req_t cpuReq,
  input  cp15Req_t mmuReq,
  input  logic [`CP15_ADDR_W-1:0] addr,
  input  logic [2:0] opcode2,
  input  logic [3:0] crm,
  output logic [`CP15_DATA_W-1:0] rd,
  output logic stall,
  output cacheOps_t ops,
  output mmuConfig_t mmuCfg
);

  // Single merged access seen by the register block and decoder
  cp15Access_t access;

  // **************************************************
  // Port merge
  // **************************************************

  cp15PortArbiter u_arbiter (
    .cpuReq  (cpuReq),
    .mmuReq  (mmuReq),
    .addr    (addr),
    .opcode2 (opcode2),
    .crm     (crm),
    .access  (access),
    .stall   (stall)
  );

  cp15RegFile u_regFile (
    .clk    (clk),
    .reset  (reset),
    .access (access),
    .rd     (rd),
    .mmuCfg (mmuCfg)
  );

  // Maintenance strobes from R7 and R8 writes
  cacheOpDecoder u_cacheOps (
    .access (access),
    .ops    (ops)
  );

endmodule

//--- bench/systemControl_chk.sv
`timescale 1ns/100ps

module systemControl_chk
  import cp15_pkg::*;
(
  input logic clk,
  input logic reset,
  input cp15Req_t cpuReq,
  input cp15Req_t mmuReq,
  input logic stall,
  input cacheOps_t ops
);

  int assertFailures = 0;
  logic cacheActive;
  logic tlbActive;
  logic anyWrite;
  logic conflict;

  assign cacheActive = ops.flushI | ops.flushD | ops.cleanI | ops.cleanD;
  assign tlbActive = ops.tlbFlushI | ops.tlbFlushD;
  // Write enables as driven by the requesters, ahead of the merge
  assign anyWrite = cpuReq.writeEn | mmuReq.writeEn;
  assign conflict = (cpuReq.writeEn & mmuReq.writeEn) | (cpuReq.en & mmuReq.en);

  // **************************************************
  // Arbiter and decoder properties
  // **************************************************

  // Sampled on the falling edge in the middle of each request cycle
  strobeNeedsWrite: assert property (
    @(negedge clk) disable iff (reset) (cacheActive || tlbActive) |-> anyWrite
  ) else begin
    assertFailures++;
    $error("maintenance strobe raised without a write");
  end

  stallOnConflict: assert property (
    @(negedge clk) disable iff (reset) stall == conflict
  ) else begin
    assertFailures++;
    $error("stall does not follow the requester conflict");
  end

  cacheTlbExclusive: assert property (
    @(negedge clk) disable iff (reset) !(cacheActive && tlbActive)
  ) else begin
    assertFailures++;
    $error("cache and TLB strobes high together");
  end

endmodule

// Top level is where the arbiter and decoder nets meet the clock
bind systemControl systemControl_chk u_chk (
  .clk    (clk),
  .reset  (reset),
  .cpuReq (cpuReq),
  .mmuReq (mmuReq),
  .stall  (stall),
  .ops    (ops)
);

//--- bench/systemControl_tb.sv
`timescale 1ns/100ps
`include "cp15_cfg.svh"

module systemControl_tb
  import cp15_pkg::*;
();

  localparam int NumVectors = 63;
  localparam int FieldsPerLine = 12;
  localparam int ResetCycles = 8;
  localparam int TimeoutCycles = NumVectors + ResetCycles + 16;
  localparam int MemWords = NumVectors * FieldsPerLine;

  logic clk = 1'b0;
  logic reset;
  cp15Req_t cpuReq;
  cp15Req_t mmuReq;
  logic [`CP15_ADDR_W-1:0] addr;
  logic [2:0] opcode2;
  logic [3:0] crm;
  logic [`CP15_DATA_W-1:0] rd;
  logic stall;
  cacheOps_t ops;
  mmuConfig_t mmuCfg;

  // One word per field, twelve words per vector line
  logic [31:0] vecMem [MemWords];

  int errorCount;
  int checkCount;
  int assertCount;
  int cycleCount = 0;

  systemControl u_systemControl (
    .clk     (clk),
    .reset   (reset),
    .cpuReq  (cpuReq),
    .mmuReq  (mmuReq),
    .addr    (addr),
    .opcode2 (opcode2),
    .crm     (crm),
    .rd      (rd),
    .stall   (stall),
    .ops     (ops),
    .mmuCfg  (mmuCfg)
  );

  // 8 ns period
  always #4 clk = ~clk;

  // **************************************************
  // Run limit
  // **************************************************

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= TimeoutCycles) begin
      $display("Timeout: the vector run did not finish within %0d cycles", TimeoutCycles);
      $display("Simulation failed");
      $finish;
    end
  end

  // Marks every word so a short vector file can be spotted
  task automatic fillMemory();
    for (int i = 0; i < MemWords; i++) begin
      vecMem[i] = {16'hbad0, i[15:0]};
    end
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] expected,
                                input logic [31:0] actual, input int line);
    errorCount++;
    $display("mismatch at %t (vector %0d): %s expected %h, got %h",
             $realtime, line, name, expected, actual);
  endtask

  task automatic driveVector(input int line);
    int base;
    base = line * FieldsPerLine;
    cpuReq.writeEn = vecMem[base][1];
    cpuReq.en = vecMem[base][0];
    cpuReq.writeData = vecMem[base + 1];
    mmuReq.writeEn = vecMem[base + 2][1];
    mmuReq.en = vecMem[base + 2][0];
    mmuReq.writeData = vecMem[base + 3];
    addr = vecMem[base + 4][3:0];
    opcode2 = vecMem[base + 5][2:0];
    crm = vecMem[base + 6][3:0];
  endtask

  // mmuCfg fields expect the state committed by earlier lines
  task automatic checkVector(input int line);
    int base;
    logic [31:0] opsWord;
    logic [31:0] stallWord;
    base = line * FieldsPerLine;
    opsWord = {26'd0, ops};
    stallWord = {31'd0, stall};
    checkCount = checkCount + 5;
    if (rd !== vecMem[base + 7]) begin
      reportMismatch("rd", vecMem[base + 7], rd, line);
    end
    if (stallWord !== vecMem[base + 8]) begin
      reportMismatch("stall", vecMem[base + 8], stallWord, line);
    end
    if (opsWord !== vecMem[base + 9]) begin
      reportMismatch("ops", vecMem[base + 9], opsWord, line);
    end
    if (mmuCfg.control !== vecMem[base + 10]) begin
      reportMismatch("mmuCfg.control", vecMem[base + 10], mmuCfg.control, line);
    end
    if (mmuCfg.tbase !== vecMem[base + 11]) begin
      reportMismatch("mmuCfg.tbase", vecMem[base + 11], mmuCfg.tbase, line);
    end
  endtask

  // **************************************************
  // Stimulus and checks
  // **************************************************

  initial begin
    $timeformat(-9, 1, " ns", 0);
    reset = 1'b1;
    cpuReq = '0;
    mmuReq = '0;
    addr = '0;
    opcode2 = '0;
    crm = '0;
    errorCount = 0;
    checkCount = 0;
    fillMemory();
    $readmemh("bench/systemControl_vectors.txt", vecMem);
    if (vecMem[MemWords - 1] === {16'hbad0, 16'(MemWords - 1)}) begin
      errorCount++;
      $display("The vector file holds fewer than %0d lines", NumVectors);
    end
    repeat (ResetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < NumVectors; i++) begin
      @(posedge clk);
      #1;
      driveVector(i);
      #2;
      checkVector(i);
    end
    @(posedge clk);
    #1;
    cpuReq = '0;
    mmuReq = '0;
    @(posedge clk);
    assertCount = u_systemControl.u_chk.assertFailures;
    $display("%0d checks, %0d mismatches, %0d assertion failures",
             checkCount, errorCount, assertCount);
    if (errorCount == 0 && assertCount == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- bench/systemControl_vectors.txt
// cpuCtl cpuData mmuCtl mmuData addr opcode2 crm | rd stall ops control tbase
// Ctl is {writeEn,en}; ops is {flushI,flushD,cleanI,cleanD,tlbFlushI,tlbFlushD}
0 00000000 0 00000000 0 0 0 00000000 0 00 00000078 00000000
1 00000000 0 00000000 0 0 0 69052d00 0 00 00000078 00000000
1 00000000 0 00000000 1 0 0 00000078 0 00 00000078 00000000
1 00000000 0 00000000 2 0 0 00000000 0 00 00000078 00000000
1 00000000 0 00000000 3 0 0 00000000 0 00 00000078 00000000
1 00000000 0 00000000 f 0 0 00000000 0 00 00000078 00000000
0 00000000 1 00000000 9 0 0 00000000 0 00 00000078 00000000
0 00000000 0 00000000 0 0 0 00000000 0 00 00000078 00000000
3 12345678 0 00000000 3 0 0 00000000 0 00 00000078 00000000
1 00000000 0 00000000 3 0 0 12345678 0 00 00000078 00000000
0 00000000 3 cafef00d 4 0 0 00000000 0 00 00000078 00000000
0 00000000 1 00000000 4 0 0 cafef00d 0 00 00000078 00000000
3 deadbeef 0 00000000 0 0 0 00000000 0 00 00000078 00000000
1 00000000 0 00000000 0 0 0 69052d00 0 00 00000078 00000000
0 00000000 3 0badf00d 0 0 0 00000000 0 00 00000078 00000000
0 00000000 1 00000000 0 0 0 69052d00 0 00 00000078 00000000
3 0000107d 0 00000000 1 0 0 00000000 0 00 00000078 00000000
1 00000000 0 00000000 1 0 0 0000107d 0 00 0000107d 00000000
0 00000000 3 00004000 2 0 0 00000000 0 00 0000107d 00000000
0 00000000 0 00000000 0 0 0 00000000 0 00 0000107d 00004000
0 00000000 1 00000000 2 0 0 00004000 0 00 0000107d 00004000
3 00000079 0 00000000 1 0 0 00000000 0 00 0000107d 00004000
0 00000000 0 00000000 0 0 0 00000000 0 00 00000079 00004000
3 00000000 0 00000000 7 0 7 00000000 0 30 00000079 00004000
3 00000000 0 00000000 7 0 5 00000000 0 20 00000079 00004000
3 00000000 0 00000000 7 0 6 00000000 0 10 00000079 00004000
3 00000000 0 00000000 7 0 b 00000000 0 0c 00000079 00004000
3 00000000 0 00000000 7 0 a 00000000 0 04 00000079 00004000
3 00000000 0 00000000 7 0 f 00000000 0 3c 00000079 00004000
3 00000000 0 00000000 7 0 e 00000000 0 14 00000079 00004000
3 00000000 0 00000000 7 1 7 00000000 0 30 00000079 00004000
3 00000000 0 00000000 7 1 5 00000000 0 20 00000079 00004000
3 00000000 0 00000000 7 1 a 00000000 0 04 00000079 00004000
3 00000000 0 00000000 7 1 e 00000000 0 14 00000079 00004000
3 00000000 0 00000000 7 2 7 00000000 0 00 00000079 00004000
3 00000000 0 00000000 7 4 f 00000000 0 00 00000079 00004000
3 00000000 0 00000000 7 0 0 00000000 0 00 00000079 00004000
3 00000000 0 00000000 7 0 9 00000000 0 00 00000079 00004000
3 00000000 0 00000000 7 0 4 00000000 0 00 00000079 00004000
0 00000000 3 00000f00 7 0 f 00000000 0 3c 00000079 00004000
1 00000000 0 00000000 7 0 f 00000f00 0 00 00000079 00004000
3 00000000 0 00000000 8 0 7 00000000 0 03 00000079 00004000
3 00000000 0 00000000 8 0 5 00000000 0 02 00000079 00004000
3 00000000 0 00000000 8 0 6 00000000 0 01 00000079 00004000
3 00000000 0 00000000 8 1 7 00000000 0 03 00000079 00004000
3 00000000 0 00000000 8 0 3 00000000 0 00 00000079 00004000
3 00000000 0 00000000 8 3 7 00000000 0 00 00000079 00004000
1 00000000 0 00000000 8 0 7 00000000 0 00 00000079 00004000
3 00000000 0 00000000 6 0 7 00000000 0 00 00000079 00004000
0 00000000 1 00000000 7 0 7 00000f00 0 00 00000079 00004000
3 11111111 3 22222222 5 0 0 00000000 1 00 00000079 00004000
1 00000000 0 00000000 5 0 0 22222222 0 00 00000079 00004000
1 00000000 1 00000000 4 0 0 cafef00d 1 00 00000079 00004000
3 aaaa5555 1 00000000 9 0 0 00000000 1 00 00000079 00004000
1 00000000 0 00000000 9 0 0 aaaa5555 0 00 00000079 00004000
0 00000000 3 5a5a5a5a a 0 0 00000000 0 00 00000079 00004000
1 00000000 1 00000000 a 0 0 5a5a5a5a 1 00 00000079 00004000
3 00000001 3 00000002 7 0 7 00000000 1 30 00000079 00004000
0 00000000 1 00000000 7 0 0 00000002 0 00 00000079 00004000
0 00000000 0 00000000 0 0 0 00000000 0 00 00000079 00004000
3 00001000 3 00008000 2 0 0 00000000 1 00 00000079 00004000
0 00000000 0 00000000 0 0 0 00000000 0 00 00000079 00008000
1 00000000 0 00000000 2 0 0 00008000 0 00 00000079 00008000

//--- compile.f
+incdir+common
common/cp15_pkg.sv
cp15/cp15PortArbiter.sv
cp15/cp15RegFile.sv
cp15/cacheOpDecoder.sv
hdl/systemControl.sv
bench/systemControl_chk.sv
bench/systemControl_tb.sv

//--- Makefile
# Verilator build and run for the CP15 system control block

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module systemControl_tb -Mdir obj_dir -f compile.f
	./obj_dir/VsystemControl_tb +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG) || \
		(echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
